/* common/link_test_consts.svh */
/*
  Link self-test sizing constants
  Word and channel widths and the clock-crossing FIFO depth
*/
`ifndef LINK_TEST_CONSTS_SVH
`define LINK_TEST_CONSTS_SVH

// One link word as seen by both clock domains
`define LINK_WIDTH 32

// Width of one channel slice
`define CHANNEL_WIDTH 8

// Link width must divide evenly into channels
`define NUM_CHANNELS (`LINK_WIDTH / `CHANNEL_WIDTH)

// Async FIFO holds 2**3 = 8 entries
`define LG_FIFO_DEPTH 3

`endif

/* common/link_test_pkg.sv */
/*
  Link self-test shared types
  Vector types for link words, channel slices and word counters
*/
`default_nettype none

`include "link_test_consts.svh"

package link_test_pkg;

  // Full word crossing the link
  typedef logic [`LINK_WIDTH-1:0] link_word_t;

  // One channel slice of a link word
  typedef logic [`CHANNEL_WIDTH-1:0] channel_word_t;

  // Sent and received word counts
  typedef logic [31:0] count_t;

endpackage

`default_nettype wire

/* logic/pattern_gen.sv */
/*
  Pattern generator
  One counter per channel, channel c starts at c, all step together
*/
`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module pattern_gen
  (input  wire logic                node_clk_i
  ,input  wire logic                node_reset_i
  ,input  wire logic                advance_i
  ,output link_test_pkg::link_word_t word_o
  );

  import link_test_pkg::*;

  channel_word_t chan_r [`NUM_CHANNELS];

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      // Word 0 has channel c equal to c
      for (int c = 0; c < `NUM_CHANNELS; c++)
      begin
        chan_r[c] <= channel_word_t'(c);
      end
    end
    else if (advance_i)
    begin
      for (int c = 0; c < `NUM_CHANNELS; c++)
      begin
        chan_r[c] <= chan_r[c] + 1'b1;
      end
    end
  end

  // Channel 0 in the low bits
  always_comb
  begin
    for (int c = 0; c < `NUM_CHANNELS; c++)
    begin
      word_o[c*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] = chan_r[c];
    end
  end

endmodule

`default_nettype wire

/* logic/async_fifo.sv */
/*
  Dual-clock FIFO
  Gray-coded pointers cross each way through two flops,
  so full and valid may lag but never overstate space or data
*/
`timescale 1ns/1ps
`default_nettype none

module async_fifo
  #(parameter int width_p    = 32
   ,parameter int lg_depth_p = 3
  )
  (input  wire logic               w_clk_i
  ,input  wire logic               w_reset_i
  ,input  wire logic               w_enq_i
  ,input  wire logic [width_p-1:0] w_data_i
  ,output logic                    w_full_o

  ,input  wire logic               r_clk_i
  ,input  wire logic               r_reset_i
  ,input  wire logic               r_deq_i
  ,output logic [width_p-1:0]      r_data_o
  ,output logic                    r_valid_o
  );

  localparam int depth_lp = 1 << lg_depth_p;

  function automatic logic [lg_depth_p:0] bin_to_gray(input logic [lg_depth_p:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  logic [width_p-1:0] mem_r [depth_lp];

  // Write domain pointers, one extra bit to tell full from empty
  logic [lg_depth_p:0] w_bin_r;
  logic [lg_depth_p:0] w_gray_r;
  logic [lg_depth_p:0] w_bin_next;
  logic [lg_depth_p:0] w_rgray_meta_r;
  logic [lg_depth_p:0] w_rgray_sync_r;
  logic                w_push;

  // Read domain pointers
  logic [lg_depth_p:0] r_bin_r;
  logic [lg_depth_p:0] r_gray_r;
  logic [lg_depth_p:0] r_bin_next;
  logic [lg_depth_p:0] r_wgray_meta_r;
  logic [lg_depth_p:0] r_wgray_sync_r;
  logic                r_pop;

  assign w_push     = w_enq_i & ~w_full_o;
  assign w_bin_next = w_bin_r + {{lg_depth_p{1'b0}}, w_push};

  // Full when the Gray pointers differ only in the top two bits
  // Needs a depth of at least 4
  assign w_full_o = (w_gray_r == {~w_rgray_sync_r[lg_depth_p -: 2],
                                  w_rgray_sync_r[lg_depth_p-2:0]});

  always_ff @(posedge w_clk_i)
  begin
    if (w_push)
    begin
      mem_r[w_bin_r[lg_depth_p-1:0]] <= w_data_i;
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_reset_i)
    begin
      w_bin_r        <= '0;
      w_gray_r       <= '0;
      w_rgray_meta_r <= '0;
      w_rgray_sync_r <= '0;
    end
    else
    begin
      w_bin_r        <= w_bin_next;
      w_gray_r       <= bin_to_gray(w_bin_next);
      w_rgray_meta_r <= r_gray_r;
      w_rgray_sync_r <= w_rgray_meta_r;
    end
  end

  assign r_valid_o  = (r_gray_r != r_wgray_sync_r);
  assign r_pop      = r_deq_i & r_valid_o;
  assign r_bin_next = r_bin_r + {{lg_depth_p{1'b0}}, r_pop};

  // Entry is stable here, its write happened before the pointer crossed
  assign r_data_o = mem_r[r_bin_r[lg_depth_p-1:0]];

  always_ff @(posedge r_clk_i)
  begin
    if (r_reset_i)
    begin
      r_bin_r        <= '0;
      r_gray_r       <= '0;
      r_wgray_meta_r <= '0;
      r_wgray_sync_r <= '0;
    end
    else
    begin
      r_bin_r        <= r_bin_next;
      r_gray_r       <= bin_to_gray(r_bin_next);
      r_wgray_meta_r <= w_gray_r;
      r_wgray_sync_r <= r_wgray_meta_r;
    end
  end

endmodule

`default_nettype wire

/* test_node/link_test_node.sv */
/*
  Link test node
  Sends a counting pattern into the link domain, checks what comes back,
  counts both directions and latches the first mismatch
*/
`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module link_test_node
  (// Node domain
   input  wire logic                       node_clk_i
  ,input  wire logic                       node_reset_i
  ,input  wire logic                       node_en_i
  ,output logic                            error_o
  ,output link_test_pkg::count_t           sent_o
  ,output link_test_pkg::count_t           received_o

  // Link domain
  ,input  wire logic                       link_clk_i
  ,input  wire logic                       link_reset_i
  ,input  wire logic                       link_v_i
  ,input  wire link_test_pkg::link_word_t  link_data_i
  ,output logic                            link_ready_o
  ,output logic                            link_v_o
  ,output link_test_pkg::link_word_t       link_data_o
  ,input  wire logic                       link_yumi_i
  );

  import link_test_pkg::*;

  link_word_t send_word;
  link_word_t check_word;
  link_word_t rx_word;
  logic       tx_full;
  logic       tx_enq;
  logic       rx_full;
  logic       rx_valid;
  logic       rx_deq;

  // Send whenever enabled and there is room
  assign tx_enq = node_en_i & ~tx_full;

  // Every returned word is taken at once
  assign rx_deq = rx_valid;

  assign link_ready_o = ~rx_full;

  pattern_gen send_gen
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.advance_i   (tx_enq)
    ,.word_o      (send_word)
    );

  pattern_gen check_gen
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.advance_i   (rx_deq)
    ,.word_o      (check_word)
    );

  // Node to link
  async_fifo #(.width_p(`LINK_WIDTH), .lg_depth_p(`LG_FIFO_DEPTH)) tx_fifo
    (.w_clk_i  (node_clk_i)
    ,.w_reset_i(node_reset_i)
    ,.w_enq_i  (tx_enq)
    ,.w_data_i (send_word)
    ,.w_full_o (tx_full)
    ,.r_clk_i  (link_clk_i)
    ,.r_reset_i(link_reset_i)
    ,.r_deq_i  (link_yumi_i)
    ,.r_data_o (link_data_o)
    ,.r_valid_o(link_v_o)
    );

  // Link back to node
  async_fifo #(.width_p(`LINK_WIDTH), .lg_depth_p(`LG_FIFO_DEPTH)) rx_fifo
    (.w_clk_i  (link_clk_i)
    ,.w_reset_i(link_reset_i)
    ,.w_enq_i  (link_v_i & link_ready_o)
    ,.w_data_i (link_data_i)
    ,.w_full_o (rx_full)
    ,.r_clk_i  (node_clk_i)
    ,.r_reset_i(node_reset_i)
    ,.r_deq_i  (rx_deq)
    ,.r_data_o (rx_word)
    ,.r_valid_o(rx_valid)
    );

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      sent_o     <= '0;
      received_o <= '0;
      error_o    <= 1'b0;
    end
    else
    begin
      if (tx_enq)
      begin
        sent_o <= sent_o + 1'b1;
      end
      if (rx_deq)
      begin
        received_o <= received_o + 1'b1;
      end
      // Sticky until reset
      if (rx_deq && (rx_word != check_word))
      begin
        error_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/link_loopback.sv */
/*
  Link loopback
  Two-entry buffer returning every word to the node, with stall
  for back-pressure and a one-shot bit 0 flip for checker tests
*/
`timescale 1ns/1ps
`default_nettype none

module link_loopback
  (input  wire logic                      link_clk_i
  ,input  wire logic                      link_reset_i
  ,input  wire logic                      link_stall_i
  ,input  wire logic                      link_corrupt_i
  ,input  wire logic                      in_v_i
  ,input  wire link_test_pkg::link_word_t in_data_i
  ,output logic                           in_yumi_o
  ,output logic                           out_v_o
  ,output link_test_pkg::link_word_t      out_data_o
  ,input  wire logic                      out_ready_i
  );

  import link_test_pkg::*;

  link_word_t buf_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       corrupt_pend_r;
  logic       give;

  // Take only with space and no stall
  assign in_yumi_o = ~link_stall_i & in_v_i & (count_r != 2'd2);

  assign out_v_o    = (count_r != 2'd0);
  assign out_data_o = buf_r[rd_ptr_r];
  assign give       = out_v_o & out_ready_i;

  always_ff @(posedge link_clk_i)
  begin
    if (in_yumi_o)
    begin
      buf_r[wr_ptr_r] <= corrupt_pend_r ? (in_data_i ^ link_word_t'(1)) : in_data_i;
    end
  end

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      wr_ptr_r       <= 1'b0;
      rd_ptr_r       <= 1'b0;
      count_r        <= 2'd0;
      corrupt_pend_r <= 1'b0;
    end
    else
    begin
      if (in_yumi_o)
      begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (give)
      begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      count_r <= count_r + {1'b0, in_yumi_o} - {1'b0, give};
      // A pulse during a take hits the following word
      corrupt_pend_r <= link_corrupt_i | (corrupt_pend_r & ~in_yumi_o);
    end
  end

endmodule

`default_nettype wire

/* logic/link_test_top.sv */
/*
  Link self-test top level
  Test node in front of the link-domain loopback
*/
`timescale 1ns/1ps
`default_nettype none

module link_test_top
  (input  wire logic            node_clk_i
  ,input  wire logic            node_reset_i
  ,input  wire logic            link_clk_i
  ,input  wire logic            link_reset_i
  ,input  wire logic            node_en_i
  ,input  wire logic            link_stall_i
  ,input  wire logic            link_corrupt_i
  ,output logic                 error_o
  ,output link_test_pkg::count_t sent_o
  ,output link_test_pkg::count_t received_o
  );

  import link_test_pkg::*;

  // Node to loopback
  logic       fwd_v;
  link_word_t fwd_data;
  logic       fwd_yumi;

  // Loopback to node
  logic       ret_v;
  link_word_t ret_data;
  logic       ret_ready;

  link_test_node link_test_node_inst
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.node_en_i   (node_en_i)
    ,.error_o     (error_o)
    ,.sent_o      (sent_o)
    ,.received_o  (received_o)
    ,.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.link_v_i    (ret_v)
    ,.link_data_i (ret_data)
    ,.link_ready_o(ret_ready)
    ,.link_v_o    (fwd_v)
    ,.link_data_o (fwd_data)
    ,.link_yumi_i (fwd_yumi)
    );

  link_loopback link_loopback_inst
    (.link_clk_i    (link_clk_i)
    ,.link_reset_i  (link_reset_i)
    ,.link_stall_i  (link_stall_i)
    ,.link_corrupt_i(link_corrupt_i)
    ,.in_v_i        (fwd_v)
    ,.in_data_i     (fwd_data)
    ,.in_yumi_o     (fwd_yumi)
    ,.out_v_o       (ret_v)
    ,.out_data_o    (ret_data)
    ,.out_ready_i   (ret_ready)
    );

endmodule

`default_nettype wire

/* tb/link_test_checker.sv */
/*
  Link test node assertions
  Sticky error, count ordering, link valid hold and send FIFO overflow
*/
`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module link_test_checker
  (input  wire logic                   node_clk_i
  ,input  wire logic                   node_reset_i
  ,input  wire logic                   link_clk_i
  ,input  wire logic                   link_reset_i
  ,input  wire logic                   error_i
  ,input  wire link_test_pkg::count_t  sent_i
  ,input  wire link_test_pkg::count_t  received_i
  ,input  wire logic                   fwd_v_i
  ,input  wire logic                   fwd_yumi_i
  ,input  wire logic                   tx_enq_i
  );

  import link_test_pkg::*;

  // Assertion failures seen so far
  int unsigned fail_count = 0;

  // Words the loopback has taken from the send FIFO
  count_t fwd_taken_r;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      fwd_taken_r <= '0;
    end
    else if (fwd_v_i && fwd_yumi_i)
    begin
      fwd_taken_r <= fwd_taken_r + 1'b1;
    end
  end

  error_sticky_a: assert property (@(posedge node_clk_i) disable iff (node_reset_i)
      $past(error_i) |-> error_i)
    else
    begin
      fail_count++;
      $error("error flag fell outside reset");
    end

  count_order_a: assert property (@(posedge node_clk_i) disable iff (node_reset_i)
      received_i <= sent_i)
    else
    begin
      fail_count++;
      $error("more words received than sent");
    end

  // Word offered to the loopback is held until taken
  fwd_hold_a: assert property (@(posedge link_clk_i) disable iff (link_reset_i || node_reset_i)
      fwd_v_i && !fwd_yumi_i |=> fwd_v_i)
    else
    begin
      fail_count++;
      $error("link valid dropped without yumi");
    end

  // Words really held in the send FIFO when another one is written
  no_overflow_a: assert property (@(posedge node_clk_i)
      disable iff (node_reset_i || link_reset_i)
      tx_enq_i |-> (sent_i - fwd_taken_r) < count_t'(1 << `LG_FIFO_DEPTH))
    else
    begin
      fail_count++;
      $error("enqueue into a full send FIFO");
    end

endmodule

bind link_test_node link_test_checker link_test_checker_inst
  (.node_clk_i  (node_clk_i)
  ,.node_reset_i(node_reset_i)
  ,.link_clk_i  (link_clk_i)
  ,.link_reset_i(link_reset_i)
  ,.error_i     (error_o)
  ,.sent_i      (sent_o)
  ,.received_i  (received_o)
  ,.fwd_v_i     (link_v_o)
  ,.fwd_yumi_i  (link_yumi_i)
  ,.tx_enq_i    (tx_enq)
  );

`default_nettype wire

/* tb/link_test_tb.sv */
/*
  Link self-test testbench
  Directed traffic, back-pressure, corruption and restart runs
*/
`timescale 1ns/1ps
`default_nettype none

module link_test_tb;

  import link_test_pkg::*;

  localparam int reset_cycles_lp  = 5;
  localparam int drain_limit_lp   = 300;
  localparam int max_in_flight_lp = 18;
  // Five tests, each well inside 800 node cycles
  localparam int test_budget_lp   = 800;
  localparam int cycle_limit_lp   = 5 * test_budget_lp;

  logic   node_clk;
  logic   node_reset;
  logic   link_clk;
  logic   link_reset;
  logic   node_en;
  logic   link_stall;
  logic   link_corrupt;
  logic   error_flag;
  count_t sent_count;
  count_t received_count;

  int errors;
  int checks;
  int assert_fails;
  int cycle_count;

  link_test_top link_test_top_inst
    (.node_clk_i    (node_clk)
    ,.node_reset_i  (node_reset)
    ,.link_clk_i    (link_clk)
    ,.link_reset_i  (link_reset)
    ,.node_en_i     (node_en)
    ,.link_stall_i  (link_stall)
    ,.link_corrupt_i(link_corrupt)
    ,.error_o       (error_flag)
    ,.sent_o        (sent_count)
    ,.received_o    (received_count)
    );

  initial
  begin
    node_clk = 1'b0;
    forever
    begin
      #50 node_clk = ~node_clk;
    end
  end

  initial
  begin
    link_clk = 1'b0;
    forever
    begin
      #35 link_clk = ~link_clk;
    end
  end

  task automatic check_count(input string what, input count_t actual, input count_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before)
    begin
      $display("%s: ok", name);
    end
    else
    begin
      $display("%s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  // Link reset follows the node reset on the link clock's falling edge
  task automatic apply_reset();
    @(negedge node_clk);
    node_reset = 1'b1;
    @(negedge link_clk);
    link_reset = 1'b1;
    repeat (reset_cycles_lp) @(negedge node_clk);
    node_reset = 1'b0;
    @(negedge link_clk);
    link_reset = 1'b0;
    @(negedge node_clk);
  endtask

  task automatic run_enabled(input int cycles);
    @(negedge node_clk);
    node_en = 1'b1;
    repeat (cycles) @(negedge node_clk);
    node_en = 1'b0;
  endtask

  task automatic set_stall(input logic value);
    @(negedge link_clk);
    link_stall = value;
  endtask

  task automatic pulse_corrupt();
    @(negedge link_clk);
    link_corrupt = 1'b1;
    @(negedge link_clk);
    link_corrupt = 1'b0;
  endtask

  // Waits for all sent words to come back, then idles so a duplicate would show
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (received_count != sent_count && waited < drain_limit_lp)
    begin
      @(negedge node_clk);
      waited++;
    end
    if (received_count != sent_count)
    begin
      errors++;
      $display("Returned words did not catch up with sent words in %0d cycles",
               drain_limit_lp);
    end
    repeat (10) @(negedge node_clk);
  endtask

  task automatic reset_state_test();
    int errors_before;
    errors_before = errors;
    apply_reset();
    check_flag("error after reset", error_flag, 1'b0);
    check_count("sent after reset", sent_count, '0);
    check_count("received after reset", received_count, '0);
    report_test("test 1 reset state", errors_before);
  endtask

  task automatic steady_traffic_test();
    int errors_before;
    errors_before = errors;
    run_enabled(40);
    repeat (100) @(negedge node_clk);
    check_count("received after steady run", received_count, sent_count);
    check_flag("words sent in steady run", sent_count > 0, 1'b1);
    check_flag("error after steady run", error_flag, 1'b0);
    report_test("test 2 steady traffic", errors_before);
  endtask

  task automatic back_pressure_test();
    int     errors_before;
    count_t sent_held;
    count_t in_flight;
    errors_before = errors;
    set_stall(1'b1);
    @(negedge node_clk);
    node_en = 1'b1;
    repeat (50) @(negedge node_clk);
    sent_held = sent_count;
    repeat (10) @(negedge node_clk);
    check_count("sent under stall", sent_count, sent_held);
    in_flight = sent_count - received_count;
    check_flag("in-flight words within bound", in_flight <= max_in_flight_lp, 1'b1);
    check_flag("in-flight words above zero", in_flight > 0, 1'b1);
    set_stall(1'b0);
    @(negedge node_clk);
    node_en = 1'b0;
    wait_drain();
    check_count("received after stall release", received_count, sent_count);
    check_flag("error after stall release", error_flag, 1'b0);
    report_test("test 3 back-pressure", errors_before);
  endtask

  task automatic corruption_test();
    int errors_before;
    errors_before = errors;
    @(negedge node_clk);
    node_en = 1'b1;
    repeat (15) @(negedge node_clk);
    pulse_corrupt();
    repeat (15) @(negedge node_clk);
    node_en = 1'b0;
    wait_drain();
    check_flag("error after corrupted word", error_flag, 1'b1);
    check_count("received after corruption", received_count, sent_count);
    report_test("test 4 corruption", errors_before);
  endtask

  task automatic restart_test();
    int errors_before;
    errors_before = errors;
    apply_reset();
    check_flag("error after second reset", error_flag, 1'b0);
    check_count("sent after second reset", sent_count, '0);
    check_count("received after second reset", received_count, '0);
    // A clean run means both generators restarted from word 0
    run_enabled(20);
    wait_drain();
    check_count("received after restart run", received_count, sent_count);
    check_flag("words sent after restart", sent_count > 0, 1'b1);
    check_flag("error after restart run", error_flag, 1'b0);
    report_test("test 5 restart", errors_before);
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < cycle_limit_lp)
    begin
      @(posedge node_clk);
      cycle_count++;
    end
    $display("Run stopped after %0d node cycles before the tests finished", cycle_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    node_reset   = 1'b1;
    link_reset   = 1'b1;
    node_en      = 1'b0;
    link_stall   = 1'b0;
    link_corrupt = 1'b0;
    errors       = 0;
    checks       = 0;

    reset_state_test();
    steady_traffic_test();
    back_pressure_test();
    corruption_test();
    restart_test();

    assert_fails = link_test_top_inst.link_test_node_inst.link_test_checker_inst.fail_count;
    $display("5 tests, %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/link_test_pkg.sv
logic/pattern_gen.sv
logic/async_fifo.sv
test_node/link_test_node.sv
logic/link_loopback.sv
logic/link_test_top.sv
tb/link_test_checker.sv
tb/link_test_tb.sv
